// ==== design/mcd_glue_pkg.sv ====
package mcd_glue_pkg;

	////////////////////
	// Widths
	////////////////////

	localparam int CDD_WIDTH  = 40;
	localparam int LINK_WIDTH = 49;
	localparam int KEY_WIDTH  = 11;

	// Host link word layout
	localparam int CD_TOGGLE_BIT = 48;
	localparam int CD_DM_BIT     = 40;

	// Keyboard word layout
	localparam int KEY_TOGGLE_BIT  = 10;
	localparam int KEY_PRESSED_BIT = 9;

	////////////////////
	// Types
	////////////////////

	typedef logic [CDD_WIDTH-1:0]  cdd_word_t;
	typedef logic [LINK_WIDTH-1:0] cd_link_t;
	typedef logic [KEY_WIDTH-1:0]  ps2_key_t;

	typedef logic [24:0] ioctl_addr_t;
	// Low byte is the earlier byte of the file
	typedef logic [15:0] ioctl_data_t;
	typedef logic [7:0]  ioctl_index_t;

	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_t;

	// Bit 1 set for 240 lines, bit 0 set for 320 wide
	typedef logic [1:0] vres_t;
	typedef logic [7:0] aspect_t;

	////////////////////
	// Codes
	////////////////////

	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;

	localparam ioctl_addr_t HDR_REGION_ADDR = 25'h1F0;

	// Compared against the low 6 bits of the download index
	localparam logic [5:0] ROM_INDEX_MAX = 6'd1;
	localparam logic [5:0] CART_INDEX    = 6'd4;

endpackage

// ==== design/cdd_link.sv ====
`timescale 1ns/1ps

module cdd_link #(
	parameter int REC_PULSE_CYCLES = 8
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  mcd_glue_pkg::cd_link_t  cd_out,
	input  mcd_glue_pkg::cdd_word_t cdd_comm,
	input  logic                    cdd_send,
	output mcd_glue_pkg::cdd_word_t cdd_stat,
	output logic                    cdd_dm,
	output logic                    cdd_rec,
	output mcd_glue_pkg::cd_link_t  cd_in
);
	import mcd_glue_pkg::*;

	logic       out_tgl_last;
	logic [7:0] rec_cnt;
	logic       send_last;
	logic       new_stat;
	logic       send_rise;

	// Host flips the toggle bit for every new status word
	assign new_stat  = cd_out[CD_TOGGLE_BIT] != out_tgl_last;
	assign send_rise = cdd_send & ~send_last;

	////////////////////
	// Status receive
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			out_tgl_last <= 1'b0;
			cdd_stat     <= '0;
			cdd_dm       <= 1'b0;
			cdd_rec      <= 1'b0;
			rec_cnt      <= '0;
		end else if (new_stat) begin
			out_tgl_last <= cd_out[CD_TOGGLE_BIT];
			cdd_stat     <= cd_out[CDD_WIDTH-1:0];
			cdd_dm       <= cd_out[CD_DM_BIT];
			// A new word mid-pulse restarts the pulse
			cdd_rec      <= 1'b1;
			rec_cnt      <= 8'(REC_PULSE_CYCLES - 1);
		end else if (rec_cnt != '0) begin
			rec_cnt <= rec_cnt - 8'd1;
		end else begin
			cdd_rec <= 1'b0;
		end
	end

	////////////////////
	// Command send
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			send_last <= 1'b0;
			cd_in     <= '0;
		end else begin
			send_last <= cdd_send;
			// One word per rising edge and nothing more while the level is held
			if (send_rise) begin
				cd_in <= {~cd_in[CD_TOGGLE_BIT], 8'h00, cdd_comm};
			end
		end
	end

endmodule

// ==== design/region_detect.sv ====
`timescale 1ns/1ps

module region_detect (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  mcd_glue_pkg::ioctl_index_t ioctl_index,
	input  logic                       ioctl_wr,
	input  mcd_glue_pkg::ioctl_addr_t  ioctl_addr,
	input  mcd_glue_pkg::ioctl_data_t  ioctl_data,
	input  mcd_glue_pkg::ps2_key_t     ps2_key,
	output mcd_glue_pkg::region_t      region_req,
	output logic                       region_set
);
	import mcd_glue_pkg::*;

	logic       rom_download;
	logic       rom_dl_last;
	logic       hdr_wr;
	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_ready;
	logic       ready_last;
	logic       key_tgl_last;
	logic       key_event;
	logic       key_pressed;
	logic [8:0] key_code;

	// BIOS indices and the cartridge index carry a header
	assign rom_download = ioctl_download &
		((ioctl_index[5:0] <= ROM_INDEX_MAX) | (ioctl_index[5:0] == CART_INDEX));
	assign hdr_wr = ioctl_wr & rom_download & (ioctl_addr == HDR_REGION_ADDR);

	assign key_event   = ps2_key[KEY_TOGGLE_BIT] != key_tgl_last;
	assign key_pressed = ps2_key[KEY_PRESSED_BIT];
	assign key_code    = ps2_key[8:0];

	////////////////////
	// Header sniffing
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_dl_last <= 1'b0;
			hdr_j       <= 1'b0;
			hdr_u       <= 1'b0;
			hdr_ready   <= 1'b0;
		end else begin
			rom_dl_last <= rom_download;
			if (rom_download & ~rom_dl_last) begin
				hdr_j     <= 1'b0;
				hdr_u     <= 1'b0;
			end
			if (~rom_download & rom_dl_last) begin
				hdr_ready <= 1'b0;
			end
			if (hdr_wr) begin
				if (ioctl_data[7:0] == "J") begin
					hdr_j <= 1'b1;
				end else if (ioctl_data[7:0] == "U") begin
					hdr_u <= 1'b1;
				end
				hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////
	// Region request
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ready_last   <= 1'b0;
			key_tgl_last <= 1'b0;
			region_req   <= region_jp;
			region_set   <= 1'b0;
		end else begin
			ready_last   <= hdr_ready;
			key_tgl_last <= ps2_key[KEY_TOGGLE_BIT];

			if (key_event) begin
				case (key_code)
					KEY_F1: begin
						region_req <= region_jp;
						region_set <= key_pressed;
					end
					KEY_F2: begin
						region_req <= region_us;
						region_set <= key_pressed;
					end
					KEY_F3: begin
						region_req <= region_eu;
						region_set <= key_pressed;
					end
					default: begin
					end
				endcase
			end

			// Header comes last so it beats a key on the same cycle
			if (hdr_ready & ~ready_last) begin
				region_set <= 1'b1;
				if (hdr_u) begin
					region_req <= region_us;
				end else if (hdr_j) begin
					region_req <= region_jp;
				end else begin
					region_req <= region_eu;
				end
			end
			if (~hdr_ready & ready_last) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

// ==== design/aspect_select.sv ====
`timescale 1ns/1ps

module aspect_select (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  mcd_glue_pkg::vres_t   resolution,
	input  logic                  vblank,
	input  logic                  ar_wide,
	input  logic                  ar_corrected,
	output mcd_glue_pkg::aspect_t video_arx,
	output mcd_glue_pkg::aspect_t video_ary
);
	import mcd_glue_pkg::*;

	vres_t res_lock;
	logic  vblank_last;

	////////////////////
	// Frame lock
	////////////////////

	// Sampled at the end of vblank so the ratio holds for the whole frame
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vblank_last <= 1'b0;
			res_lock    <= 2'b00;
		end else begin
			vblank_last <= vblank;
			if (vblank_last & ~vblank) begin
				res_lock <= resolution;
			end
		end
	end

	////////////////////
	// Ratio table
	////////////////////

	always_comb begin
		if (ar_wide) begin
			video_arx = 8'd16;
			video_ary = 8'd9;
		end else begin
			case (res_lock)
				// 256x224
				2'b00: begin
					video_arx = 8'd64;
					video_ary = 8'd49;
				end
				// 320x224
				2'b01: begin
					video_arx = ar_corrected ? 8'd10 : 8'd64;
					video_ary = ar_corrected ? 8'd7 : 8'd49;
				end
				// 256x240
				2'b10: begin
					video_arx = 8'd128;
					video_ary = 8'd105;
				end
				// 320x240
				default: begin
					video_arx = ar_corrected ? 8'd4 : 8'd128;
					video_ary = ar_corrected ? 8'd3 : 8'd105;
				end
			endcase
		end
	end

endmodule

// ==== design/mcd_glue_top.sv ====
`timescale 1ns/1ps

module mcd_glue_top #(
	parameter int REC_PULSE_CYCLES = 8
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	// CD drive link
	input  mcd_glue_pkg::cd_link_t     cd_out,
	input  logic                       cdd_send,
	input  mcd_glue_pkg::cdd_word_t    cdd_comm,
	output mcd_glue_pkg::cdd_word_t    cdd_stat,
	output logic                       cdd_dm,
	output logic                       cdd_rec,
	output mcd_glue_pkg::cd_link_t     cd_in,
	// Downloads and keyboard
	input  mcd_glue_pkg::ps2_key_t     ps2_key,
	input  logic                       ioctl_download,
	input  mcd_glue_pkg::ioctl_index_t ioctl_index,
	input  logic                       ioctl_wr,
	input  mcd_glue_pkg::ioctl_addr_t  ioctl_addr,
	input  mcd_glue_pkg::ioctl_data_t  ioctl_data,
	output mcd_glue_pkg::region_t      region_req,
	output logic                       region_set,
	// Video
	input  mcd_glue_pkg::vres_t        resolution,
	input  logic                       vblank,
	input  logic                       ar_wide,
	input  logic                       ar_corrected,
	output mcd_glue_pkg::aspect_t      video_arx,
	output mcd_glue_pkg::aspect_t      video_ary
);

	cdd_link #(
		.REC_PULSE_CYCLES(REC_PULSE_CYCLES)
	) cdd_link_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cd_out   (cd_out),
		.cdd_comm (cdd_comm),
		.cdd_send (cdd_send),
		.cdd_stat (cdd_stat),
		.cdd_dm   (cdd_dm),
		.cdd_rec  (cdd_rec),
		.cd_in    (cd_in)
	);

	region_detect region_detect_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ps2_key        (ps2_key),
		.region_req     (region_req),
		.region_set     (region_set)
	);

	aspect_select aspect_select_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.resolution   (resolution),
		.vblank       (vblank),
		.ar_wide      (ar_wide),
		.ar_corrected (ar_corrected),
		.video_arx    (video_arx),
		.video_ary    (video_ary)
	);

endmodule

// ==== include/mcd_glue_ref.svh ====
`ifndef MCD_GLUE_REF_SVH
`define MCD_GLUE_REF_SVH

////////////////////
// Expected values
////////////////////

// U beats J and any other header byte means EU
function automatic region_t exp_region(input logic [7:0] hdr_byte);
	if (hdr_byte == "U") begin
		return region_us;
	end else if (hdr_byte == "J") begin
		return region_jp;
	end
	return region_eu;
endfunction

// Result is {region_set, region_req}
// Unknown codes keep the current state
function automatic logic [2:0] exp_region_key(input logic [8:0] code, input logic pressed,
		input logic [2:0] cur);
	case (code)
		9'h005: return {pressed, region_jp};
		9'h006: return {pressed, region_us};
		9'h004: return {pressed, region_eu};
		default: return cur;
	endcase
endfunction

// Result is {arx, ary}
function automatic logic [15:0] exp_aspect(input vres_t res, input logic wide,
		input logic corrected);
	if (wide) begin
		return {8'd16, 8'd9};
	end
	case (res)
		2'b00: return {8'd64, 8'd49};
		2'b01: return corrected ? {8'd10, 8'd7} : {8'd64, 8'd49};
		2'b10: return {8'd128, 8'd105};
		default: return corrected ? {8'd4, 8'd3} : {8'd128, 8'd105};
	endcase
endfunction

// Toggle flips with every command and bits 47..40 stay zero
function automatic cd_link_t exp_cd_in(input cd_link_t prev, input cdd_word_t comm);
	return {~prev[48], 8'h00, comm};
endfunction

`endif

// ==== dv/tb_mcd_glue.sv ====
`timescale 1ns/1ps

module tb_mcd_glue;
	import mcd_glue_pkg::*;
	`include "mcd_glue_ref.svh"

	localparam int REC_CYCLES = 8;
	// Well above the summed length of all tests
	localparam int MAX_CYCLES = 3000;

	logic        clk_sys;
	logic        reset;
	cd_link_t    cd_out;
	logic        cdd_send;
	cdd_word_t   cdd_comm;
	cdd_word_t   cdd_stat;
	logic        cdd_dm;
	logic        cdd_rec;
	cd_link_t    cd_in;
	ps2_key_t    ps2_key;
	logic        ioctl_download;
	ioctl_index_t ioctl_index;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_data;
	region_t     region_req;
	logic        region_set;
	vres_t       resolution;
	logic        vblank;
	logic        ar_wide;
	logic        ar_corrected;
	aspect_t     video_arx;
	aspect_t     video_ary;

	// Expectations published by the stimulus
	logic        chk_stat = 1'b0;
	logic        chk_rec = 1'b0;
	logic        chk_cdin = 1'b0;
	logic        chk_region = 1'b0;
	logic        chk_aspect = 1'b0;
	cdd_word_t   exp_stat;
	logic        exp_dm;
	logic        exp_rec;
	cd_link_t    exp_in;
	logic [1:0]  exp_req;
	logic        exp_set;
	logic [15:0] exp_ar;

	logic [1:0]  region_model;
	logic [2:0]  key_model;
	vres_t       lock_model;
	int          errors = 0;
	int          errors_before = 0;
	int          tests = 0;
	int          cycles = 0;

	mcd_glue_top #(
		.REC_PULSE_CYCLES(REC_CYCLES)
	) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles with tests unfinished", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic report_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		errors++;
	endtask

	////////////////////
	// Compare
	////////////////////

	// Sampled mid-cycle away from the drive point
	always @(negedge clk_sys) begin
		if (chk_stat) begin
			assert (cdd_stat == exp_stat) else report_value("cdd_stat", exp_stat, cdd_stat);
			assert (cdd_dm == exp_dm) else report_value("cdd_dm", exp_dm, cdd_dm);
		end
		if (chk_rec) begin
			assert (cdd_rec == exp_rec) else report_value("cdd_rec", exp_rec, cdd_rec);
		end
		if (chk_cdin) begin
			assert (cd_in == exp_in) else report_value("cd_in", exp_in, cd_in);
		end
		if (chk_region) begin
			assert (region_req == exp_req)
				else report_value("region_req", exp_req, region_req);
			assert (region_set == exp_set)
				else report_value("region_set", exp_set, region_set);
		end
		if (chk_aspect) begin
			assert (video_arx == exp_ar[15:8])
				else report_value("video_arx", exp_ar[15:8], video_arx);
			assert (video_ary == exp_ar[7:0])
				else report_value("video_ary", exp_ar[7:0], video_ary);
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic end_test(input string name);
		$display("test %-16s done, %0d errors", name, errors - errors_before);
		errors_before = errors;
		tests++;
	endtask

	task automatic download(input logic [7:0] index, input logic [7:0] hdr_byte);
		logic is_rom;
		is_rom = (index[5:0] <= 6'd1) || (index[5:0] == 6'd4);
		ioctl_index = index;
		ioctl_download = 1'b1;
		step();
		ioctl_addr = 25'h1F0;
		ioctl_data = {8'($urandom()), hdr_byte};
		ioctl_wr = 1'b1;
		step();
		ioctl_wr = 1'b0;
		step();
		// Two cycles after the header strobe
		if (is_rom) begin
			region_model = exp_region(hdr_byte);
		end
		exp_req = region_model;
		exp_set = is_rom;
		chk_region = 1'b1;
		step();
		chk_region = 1'b0;
		ioctl_download = 1'b0;
		step();
		step();
		exp_set = 1'b0;
		chk_region = 1'b1;
		step();
		chk_region = 1'b0;
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed);
		ps2_key = {~ps2_key[10], pressed, code};
		step();
		key_model = exp_region_key(code, pressed, key_model);
		{exp_set, exp_req} = key_model;
		chk_region = 1'b1;
		step();
		chk_region = 1'b0;
	endtask

	initial begin
		cdd_word_t word;
		cd_link_t  cdin_model;
		logic      dm;
		void'($urandom(32'he4df_6a0c));
		reset = 1'b1;
		cd_out = '0;
		cdd_send = 1'b0;
		cdd_comm = '0;
		ps2_key = '0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		resolution = 2'b00;
		vblank = 1'b0;
		ar_wide = 1'b0;
		ar_corrected = 1'b0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Reset values
		exp_stat = '0;
		exp_dm = 1'b0;
		exp_rec = 1'b0;
		exp_in = '0;
		exp_req = region_jp;
		exp_set = 1'b0;
		exp_ar = exp_aspect(2'b00, 1'b0, 1'b0);
		{chk_stat, chk_rec, chk_cdin, chk_region, chk_aspect} = 5'b11111;
		step();
		{chk_stat, chk_rec, chk_cdin, chk_region, chk_aspect} = 5'b00000;
		end_test("reset");

		for (int i = 0; i < 20; i++) begin
			word = {8'($urandom()), $urandom()};
			dm = 1'($urandom());
			cd_out = {~cd_out[48], 7'h00, dm, word};
			step();
			exp_stat = word;
			exp_dm = dm;
			exp_rec = 1'b1;
			chk_stat = 1'b1;
			chk_rec = 1'b1;
			repeat (REC_CYCLES - 1) step();
			step();
			exp_rec = 1'b0;
		end
		step();
		chk_stat = 1'b0;
		chk_rec = 1'b0;
		end_test("status receive");

		cdin_model = '0;
		for (int i = 0; i < 20; i++) begin
			word = {8'($urandom()), $urandom()};
			cdd_comm = word;
			cdd_send = 1'b1;
			step();
			cdin_model = exp_cd_in(cdin_model, word);
			exp_in = cdin_model;
			chk_cdin = 1'b1;
			// A new command under a held send level must not go out
			cdd_comm = {8'($urandom()), $urandom()};
			repeat ($urandom_range(4)) step();
			cdd_send = 1'b0;
			repeat ($urandom_range(3, 1)) step();
		end
		chk_cdin = 1'b0;
		end_test("command send");

		region_model = region_jp;
		download(8'd0, "J");
		download(8'd1, "U");
		download(8'd4, "Q");
		download(8'd2, "U");
		download(8'h41, "J");
		end_test("header region");

		key_model = {1'b0, region_model};
		key_event(9'h005, 1'b1);
		key_event(9'h005, 1'b0);
		key_event(9'h006, 1'b1);
		key_event(9'h01C, 1'b0);
		key_event(9'h004, 1'b1);
		key_event(9'h004, 1'b0);
		end_test("keyboard region");

		lock_model = 2'b00;
		for (int i = 0; i < 16; i++) begin
			resolution = 2'(i);
			ar_wide = i[2];
			ar_corrected = i[3];
			step();
			// Mid-frame change keeps the old ratio
			exp_ar = exp_aspect(lock_model, ar_wide, ar_corrected);
			chk_aspect = 1'b1;
			step();
			vblank = 1'b1;
			step();
			vblank = 1'b0;
			step();
			lock_model = resolution;
			exp_ar = exp_aspect(lock_model, ar_wide, ar_corrected);
			step();
			chk_aspect = 1'b0;
		end
		end_test("aspect lock");

		$display("Tests: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== mcd_glue.f ====
+incdir+include
design/mcd_glue_pkg.sv
design/cdd_link.sv
design/region_detect.sv
design/aspect_select.sv
design/mcd_glue_top.sv
dv/tb_mcd_glue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_mcd_glue -f mcd_glue.f -o tb_mcd_glue

./obj_dir/tb_mcd_glue > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
